// ==== Makefile ====
# Verilator flow for the 64b/66b loopback testbench

VERILATOR ?= verilator
TOP       ?= tb_eth_loopback
FILELIST  ?= files.f
BYPASS    ?= 0
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal -GSCRAMBLER_BYPASS=$(BYPASS)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides the result, the binary status is not used
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "no result found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== eth_loopback_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_loopback_top import eth_pkg::*; #(
    parameter bit SCRAMBLER_BYPASS = 1'b0
) (
    input  wire             init_clk,
    input  wire             vio_reset_out,
    input  wire [LEN_W-1:0] packet_length,
    input  wire [PAT_W-1:0] pattern,
    output wire block_t     tx_block,
    input  wire block_t     rx_block,
    output wire rx_beat_t   rx_beat,
    output wire             rx_valid,
    output wire [31:0]      frame_count,
    output wire [31:0]      error_count
);

    logic   tvalid;
    logic   tready;
    beat_t  gen_beat;   // generator to encoder
    block_t enc_block;  // encoder to scrambler
    block_t dsc_block;  // descrambler to decoder

    packet_gen #(
        .LEN_W(LEN_W)
    ) u_packet_gen (
        .init_clk     (init_clk),
        .vio_reset_out(vio_reset_out),
        .packet_length(packet_length),
        .pattern      (pattern),
        .tready       (tready),
        .tvalid       (tvalid),
        .beat         (gen_beat)
    );

    pcs_tx u_pcs_tx (
        .init_clk     (init_clk),
        .vio_reset_out(vio_reset_out),
        .tvalid       (tvalid),
        .beat         (gen_beat),
        .tready       (tready),
        .block        (enc_block)
    );

    scrambler #(
        .DESCRAMBLE(1'b0),
        .BYPASS    (SCRAMBLER_BYPASS)
    ) u_tx_scrambler (
        .init_clk     (init_clk),
        .vio_reset_out(vio_reset_out),
        .block_in     (enc_block),
        .block_out    (tx_block)
    );

    // loop closes outside, rx_block comes back from the line
    scrambler #(
        .DESCRAMBLE(1'b1),
        .BYPASS    (SCRAMBLER_BYPASS)
    ) u_rx_descrambler (
        .init_clk     (init_clk),
        .vio_reset_out(vio_reset_out),
        .block_in     (rx_block),
        .block_out    (dsc_block)
    );

    pcs_rx u_pcs_rx (
        .init_clk     (init_clk),
        .vio_reset_out(vio_reset_out),
        .block        (dsc_block),
        .rx_beat      (rx_beat),
        .rx_valid     (rx_valid)
    );

    packet_check u_packet_check (
        .init_clk     (init_clk),
        .vio_reset_out(vio_reset_out),
        .packet_length(packet_length),
        .pattern      (pattern),
        .rx_beat      (rx_beat),
        .rx_valid     (rx_valid),
        .frame_count  (frame_count),
        .error_count  (error_count)
    );

endmodule

`default_nettype wire

// ==== eth_pkg.sv ====
`default_nettype none

package eth_pkg;

    localparam int LEN_W = 16;  // packet index and length
    localparam int PAT_W = 48;  // pattern above the index

    // 64b/66b sync headers
    localparam logic [1:0] HDR_DATA = 2'b01;
    localparam logic [1:0] HDR_CTRL = 2'b10;

    // control block types, low payload byte
    localparam logic [7:0] CTRL_IDLE = 8'h1e;
    localparam logic [7:0] CTRL_TERM = 8'h87;

    // one transmit beat
    typedef struct packed {
        logic [63:0] data;
        logic        last;
    } beat_t;

    // one received beat, user marks a decode error
    typedef struct packed {
        logic [63:0] data;
        logic        last;
        logic        user;
    } rx_beat_t;

    // one 66-bit line block
    typedef struct packed {
        logic [1:0]  header;
        logic [63:0] payload;
    } block_t;

    // checker counters
    typedef struct packed {
        logic [31:0] frames;
        logic [31:0] errors;
    } status_t;

    localparam block_t IDLE_BLOCK = '{header: HDR_CTRL, payload: {56'h0, CTRL_IDLE}};
    localparam block_t TERM_BLOCK = '{header: HDR_CTRL, payload: {56'h0, CTRL_TERM}};

endpackage

`default_nettype wire

// ==== files.f ====
eth_pkg.sv
packet_gen.sv
pcs_tx.sv
scrambler.sv
pcs_rx.sv
packet_check.sv
eth_loopback_top.sv
tb_clk_gen.sv
tb_eth_loopback.sv

// ==== packet_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_check import eth_pkg::*; (
    input  wire              init_clk,
    input  wire              vio_reset_out,
    input  wire  [LEN_W-1:0] packet_length,
    input  wire  [PAT_W-1:0] pattern,
    input  wire  rx_beat_t   rx_beat,
    input  wire              rx_valid,
    output logic [31:0]      frame_count,
    output logic [31:0]      error_count
);

    status_t          stat;
    logic [LEN_W-1:0] exp_idx;   // index the next beat should carry
    logic             exp_last;  // next beat should close the packet
    logic             idx_bad;
    logic             pat_bad;
    logic             beat_bad;

    assign exp_last = (exp_idx == packet_length);
    assign idx_bad  = (rx_beat.data[LEN_W-1:0] != exp_idx);
    assign pat_bad  = (rx_beat.data[63:LEN_W] != pattern);

    // any single mismatch marks the whole beat
    assign beat_bad = rx_beat.user || idx_bad || pat_bad || (rx_beat.last != exp_last);

    always_ff @(posedge init_clk) begin
        if (vio_reset_out) begin
            stat    <= '0;
            exp_idx <= '0;
        end else if (rx_valid) begin
            if (beat_bad) begin
                stat.errors <= stat.errors + 1'b1;
            end
            if (rx_beat.last) begin
                stat.frames <= stat.frames + 1'b1;
            end

            // realign on a received last, even a misplaced one
            if (rx_beat.last || exp_last) begin
                exp_idx <= '0;
            end else begin
                exp_idx <= exp_idx + 1'b1;
            end
        end
    end

    assign frame_count = stat.frames;
    assign error_count = stat.errors;

endmodule

`default_nettype wire

// ==== packet_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_gen import eth_pkg::*; #(
    parameter int LEN_W = eth_pkg::LEN_W
) (
    input  wire              init_clk,
    input  wire              vio_reset_out,
    input  wire  [LEN_W-1:0] packet_length,
    input  wire  [PAT_W-1:0] pattern,
    input  wire              tready,
    output logic             tvalid,
    output beat_t            beat
);

    logic [LEN_W-1:0] idx;       // position within the packet
    logic             idx_end;   // final beat of the packet

    assign idx_end = (idx == packet_length);

    // index only moves while the encoder takes beats
    always_ff @(posedge init_clk) begin
        if (vio_reset_out) begin
            idx    <= '0;
            tvalid <= 1'b0;
        end else begin
            tvalid <= 1'b1;  // always something to send once running
            if (tready) begin
                if (idx_end) begin
                    idx <= '0;  // wrap for next packet
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // pattern sits above the index, index in the low bits
    assign beat.data = {pattern, idx};
    assign beat.last = idx_end;

endmodule

`default_nettype wire

// ==== pcs_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcs_rx import eth_pkg::*; (
    input  wire         init_clk,
    input  wire         vio_reset_out,
    input  wire block_t block,
    output rx_beat_t    rx_beat,
    output logic        rx_valid
);

    logic in_data;   // data header
    logic in_ctrl;   // control header
    logic in_term;   // terminate block
    logic in_idle;   // idle block
    logic in_bad;    // bad header or unknown control type

    logic        held_valid;  // a beat waits for its follower
    logic        held_bad;    // held block came in with a bad header
    logic [63:0] held_data;

    assign in_data = (block.header == HDR_DATA);
    assign in_ctrl = (block.header == HDR_CTRL);
    assign in_term = in_ctrl && (block.payload[7:0] == CTRL_TERM);
    assign in_idle = in_ctrl && (block.payload[7:0] == CTRL_IDLE);

    // 00 and 11 headers are never legal
    assign in_bad = !(in_data || in_ctrl) || (in_ctrl && !in_term && !in_idle);

    // anything not a control block is kept as a beat
    always_ff @(posedge init_clk) begin
        if (vio_reset_out) begin
            held_valid <= 1'b0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid   <= held_valid;  // release on every following block
            held_valid <= !in_ctrl;
        end
    end

    // payload side
    always_ff @(posedge init_clk) begin
        held_data <= block.payload;
        held_bad  <= !in_data;  // only read when held_valid

        // follower decides last, either block can flag an error
        rx_beat.data <= held_data;
        rx_beat.last <= in_term;
        rx_beat.user <= held_bad || in_bad;
    end

endmodule

`default_nettype wire

// ==== pcs_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcs_tx import eth_pkg::*; (
    input  wire        init_clk,
    input  wire        vio_reset_out,
    input  wire        tvalid,
    input  wire beat_t beat,
    output logic       tready,
    output block_t     block
);

    logic accept;        // beat handed over this cycle
    logic end_of_frame;  // accepted beat closes the packet
    logic term_pending;  // terminate owed to the line

    assign accept       = tvalid && tready;
    assign end_of_frame = accept && beat.last;

    // ready drops for exactly the cycle the terminate is loaded
    always_ff @(posedge init_clk) begin
        if (vio_reset_out) begin
            tready       <= 1'b0;
            term_pending <= 1'b0;
        end else begin
            tready       <= !end_of_frame;
            term_pending <= end_of_frame;
        end
    end

    // one block per cycle
    // data takes priority, then terminate, otherwise idle fill
    always_ff @(posedge init_clk) begin
        if (vio_reset_out) begin
            block <= IDLE_BLOCK;
        end else if (accept) begin
            block.header  <= HDR_DATA;
            block.payload <= beat.data;
        end else if (term_pending) begin
            block <= TERM_BLOCK;  // closes the frame on the line
        end else begin
            block <= IDLE_BLOCK;  // nothing to send
        end
    end

endmodule

`default_nettype wire

// ==== scrambler.sv ====
`timescale 1ns/1ps
`default_nettype none

module scrambler import eth_pkg::*; #(
    parameter bit DESCRAMBLE = 1'b0,
    parameter bit BYPASS     = 1'b0
) (
    input  wire         init_clk,
    input  wire         vio_reset_out,
    input  wire block_t block_in,
    output block_t      block_out
);

    logic [57:0] state;       // last 58 line bits, bit 57 newest
    logic [63:0] mixed;       // scrambled or descrambled payload
    logic [57:0] state_next;

    // 1 + x^39 + x^58, bit 0 goes first on the line
    always_comb begin
        logic [121:0] line;  // history in 57:0, current word above
        line = {block_in.payload, state};
        for (int i = 0; i < 64; i++) begin
            mixed[i] = block_in.payload[i] ^ line[i + 19] ^ line[i];
            if (!DESCRAMBLE) begin
                line[58 + i] = mixed[i];  // feedback taps see scrambled bits
            end
        end
        state_next = line[121:64];
    end

    always_ff @(posedge init_clk) begin
        if (vio_reset_out) begin
            state     <= '0;
            block_out <= IDLE_BLOCK;
        end else begin
            state             <= state_next;
            block_out.header  <= block_in.header;  // header never scrambled
            block_out.payload <= BYPASS ? block_in.payload : mixed;
        end
    end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 16
) (
    input  wire  reset_req,      // rerun the reset sequence
    output logic init_clk,
    output logic vio_reset_out
);

    initial begin
        init_clk = 1'b0;
        forever #(HALF_PERIOD) init_clk = ~init_clk;
    end

    // reset seen by RESET_CYCLES edges, released 1 ns after the last one
    initial begin
        vio_reset_out = 1'b1;
        forever begin
            repeat (RESET_CYCLES) @(posedge init_clk);
            #1 vio_reset_out = 1'b0;
            @(posedge reset_req);
            @(posedge init_clk);
            #1 vio_reset_out = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tb_eth_loopback.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_eth_loopback import eth_pkg::*; #(
    parameter bit SCRAMBLER_BYPASS = 1'b0
);

    localparam int N_PKTS      = 20;  // checked packets per phase
    localparam int DRAIN_PKTS  = 2;   // extra packets so the rx side catches up
    localparam int RESET_CYC   = 16;
    localparam int PHASE_CYC   = (N_PKTS + DRAIN_PKTS) * 17 + RESET_CYC + 10;
    localparam int CYCLE_LIMIT = 3 * PHASE_CYC + 100;

    logic             init_clk;
    logic             vio_reset_out;
    logic             reset_req;
    logic [LEN_W-1:0] packet_length;
    logic [PAT_W-1:0] pattern;
    block_t           tx_block;
    block_t           rx_block;
    rx_beat_t         rx_beat;
    logic             rx_valid;
    logic [31:0]      frame_count;
    logic [31:0]      error_count;

    logic [31:0]      lcg_state;
    logic [57:0]      scr_state;      // model line history with bit 0 newest
    logic [LEN_W-1:0] m_idx;
    logic             term_due;
    logic             pkt_corrupted;
    int               lead_idles;
    int               pkts_tx;        // terminates produced by the model
    int               frames_rx;
    int               user_seen;
    int               corruptions;
    rx_beat_t         exp_q[$];
    int               value_errors = 0;
    int               other_errors = 0;
    int               cycles = 0;

    tb_clk_gen #(.HALF_PERIOD(10), .RESET_CYCLES(RESET_CYC)) clk_gen_i (
        .reset_req    (reset_req),
        .init_clk     (init_clk),
        .vio_reset_out(vio_reset_out)
    );

    eth_loopback_top #(.SCRAMBLER_BYPASS(SCRAMBLER_BYPASS)) dut_i (
        .init_clk     (init_clk),
        .vio_reset_out(vio_reset_out),
        .packet_length(packet_length),
        .pattern      (pattern),
        .tx_block     (tx_block),
        .rx_block     (rx_block),
        .rx_beat      (rx_beat),
        .rx_valid     (rx_valid),
        .frame_count  (frame_count),
        .error_count  (error_count)
    );

    always @(posedge init_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic block_t ctrl_block(input logic [7:0] kind);
        block_t blk;
        blk.header  = HDR_CTRL;
        blk.payload = {56'h0, kind};  // type in the low byte
        return blk;
    endfunction

    // serial 1 + x^39 + x^58 over a history of scrambled line bits
    function automatic block_t scramble_block(input block_t blk);
        block_t res;
        logic   line_bit;
        res = blk;
        for (int i = 0; i < 64; i++) begin
            line_bit       = blk.payload[i] ^ scr_state[38] ^ scr_state[57];
            res.payload[i] = line_bit;
            scr_state      = {scr_state[56:0], line_bit};
        end
        if (SCRAMBLER_BYPASS) begin
            res.payload = blk.payload;
        end
        return res;
    endfunction

    // leading idles and then beats with a terminate after each last
    task automatic next_model_block(output block_t blk);
        rx_beat_t bt;
        if (lead_idles > 0) begin
            lead_idles--;
            blk = ctrl_block(CTRL_IDLE);
        end else if (term_due) begin
            term_due      = 1'b0;
            pkt_corrupted = 1'b0;
            pkts_tx++;
            blk = ctrl_block(CTRL_TERM);
        end else begin
            blk.header  = HDR_DATA;
            blk.payload = {pattern, m_idx};
            bt.data     = blk.payload;
            bt.last     = (m_idx == packet_length);
            bt.user     = 1'b0;
            exp_q.push_back(bt);
            term_due = bt.last;
            m_idx    = bt.last ? '0 : m_idx + LEN_W'(1);  // no index skipped or repeated
        end
    endtask

    task automatic check_block(input string name, input block_t exp, input block_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_beat(input string name, input rx_beat_t exp, input rx_beat_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic next_cycle();
        @(posedge init_clk);
        #1;
    endtask

    // new length and pattern go in while reset is held
    task automatic start_phase(input logic [LEN_W-1:0] len, input logic [PAT_W-1:0] pat,
                               input bit request);
        if (request) begin
            reset_req = 1'b1;
            @(posedge vio_reset_out);
            reset_req = 1'b0;
        end
        next_cycle();
        packet_length = len;
        pattern       = pat;
        rx_block      = ctrl_block(CTRL_IDLE);
        next_cycle();
        check_count("frame_count", 32'd0, frame_count);
        check_count("error_count", 32'd0, error_count);
        check_count("rx_valid", 32'd0, {31'd0, rx_valid});
        check_block("tx_block", ctrl_block(CTRL_IDLE), tx_block);
        @(negedge vio_reset_out);
        scr_state     = '0;
        m_idx         = '0;
        term_due      = 1'b0;
        pkt_corrupted = 1'b0;
        lead_idles    = 2;  // reset value and the cycle before tready rises
        pkts_tx       = 0;
        frames_rx     = 0;
        user_seen     = 0;
        corruptions   = 0;
        exp_q.delete();
    endtask

    task automatic run_phase(input bit corrupt_en);
        block_t      exp_blk;
        block_t      fwd;
        rx_beat_t    exp_beat;
        logic [31:0] rnd;
        while (pkts_tx < N_PKTS + DRAIN_PKTS) begin
            next_cycle();
            next_model_block(exp_blk);
            check_block("tx_block", scramble_block(exp_blk), tx_block);

            // counters trail rx_valid by one cycle
            if (corrupt_en) begin
                if (frame_count > 32'(pkts_tx)) begin
                    value_errors++;
                    $display("[FAIL] frame_count 0x%h above packets sent 0x%h", frame_count,
                             32'(pkts_tx));
                end
            end else begin
                check_count("frame_count", 32'(frames_rx), frame_count);
                check_count("error_count", 32'd0, error_count);
            end
            if (rx_valid && corrupt_en) begin
                user_seen += rx_beat.user;
            end else if (rx_valid && exp_q.size() == 0) begin
                other_errors++;
                $display("rx_beat arrived with no beat left in the model at %0t", $time);
            end else if (rx_valid) begin
                exp_beat = exp_q.pop_front();
                frames_rx += exp_beat.last;
                check_beat("rx_beat", exp_beat, rx_beat);
            end

            // loop back with at most one flipped data header per packet
            fwd = tx_block;
            if (corrupt_en && exp_blk.header == HDR_DATA && !pkt_corrupted &&
                exp_blk.payload[LEN_W-1:0] != '0 && pkts_tx < N_PKTS) begin
                rnd = lcg_next();
                if (rnd[21:20] == 2'b00) begin
                    fwd.header    = ~fwd.header;
                    pkt_corrupted = 1'b1;
                    corruptions++;
                end
            end
            rx_block = fwd;
        end

        if (corrupt_en) begin
            check_count("user beats", 32'(corruptions), 32'(user_seen));
            if (error_count < 32'(corruptions)) begin
                value_errors++;
                $display("[FAIL] error_count 0x%h below corruptions 0x%h", error_count,
                         32'(corruptions));
            end
        end else if (frames_rx < N_PKTS) begin
            other_errors++;
            $display("only %0d frames came back out of %0d sent", frames_rx, N_PKTS);
        end
    endtask

    initial begin
        logic [31:0]      rnd;
        logic [31:0]      rnd2;
        logic [LEN_W-1:0] len;
        logic [LEN_W-1:0] prev_len;
        logic [PAT_W-1:0] pat;
        lcg_state     = 32'hbe9c21da;
        reset_req     = 1'b0;
        packet_length = '0;
        pattern       = '0;
        rx_block      = ctrl_block(CTRL_IDLE);
        prev_len      = '0;
        for (int ph = 1; ph <= 3; ph++) begin
            rnd = lcg_next();
            len = LEN_W'(rnd[15:8] % 8'd15) + LEN_W'(1);
            if (len == prev_len) begin
                len = (len % LEN_W'(15)) + LEN_W'(1);  // force a new length after reset
            end
            rnd  = lcg_next();
            rnd2 = lcg_next();
            pat  = {rnd[31:16], rnd2};
            $display("phase %0d: packet_length %0d pattern 0x%h", ph, len, pat);
            start_phase(len, pat, ph != 1);
            run_phase(ph == 3);
            prev_len = len;
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
